//--- all.f
src/cache_pkg.sv
src/cache_array.sv
src/bank_mem.sv
src/cache_controller.sv
src/cache_top.sv
tb/cache_props.sv
tb/tb_cache_top.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --assert --timing --top-module tb_cache_top -f all.f -Mdir obj_dir &&
./obj_dir/Vtb_cache_top ||
{ echo "Simulation failed"; exit 1; }

//--- src/bank_mem.sv
`timescale 1ns/1ps
`default_nettype none

module bank_mem import cache_pkg::*; (
	input  logic        clk,
	input  logic        arst_n,
	input  mem_req_t    req,
	output logic [15:0] rdata
);

	typedef struct packed {
		logic        valid;
		logic [15:0] data;
	} rd_stage_t;

	// One bank per word offset
	logic [15:0] mem [2**WORDS_LOG2][2**(TAG_W+INDEX_W)];

	rd_stage_t pipe [2**WORDS_LOG2][MEM_LAT];

	logic [TAG_W+INDEX_W-1:0] line;

	assign line = {req.addr.tag, req.addr.index}; // Word position inside a bank

	initial begin
		for (int b = 0; b < 2**WORDS_LOG2; b++) begin
			for (int w = 0; w < 2**(TAG_W+INDEX_W); w++) begin
				mem[b][w] = '0;
			end
		end
	end

	always @(posedge clk) begin
		if (req.wr) begin
			mem[req.addr.offset][line] <= req.wdata; // Lands at the command edge
		end
	end

	// Each bank runs its own read pipeline so reads to different banks overlap
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int b = 0; b < 2**WORDS_LOG2; b++) begin
				for (int k = 0; k < MEM_LAT; k++) begin
					pipe[b][k] <= '0;
				end
			end
		end else begin
			for (int b = 0; b < 2**WORDS_LOG2; b++) begin
				pipe[b][0].valid <= req.rd && (req.addr.offset == WORDS_LOG2'(b));
				pipe[b][0].data  <= mem[b][line];
				for (int k = 1; k < MEM_LAT; k++) begin
					pipe[b][k] <= pipe[b][k-1];
				end
			end
		end
	end

	always_comb begin
		rdata = '0;
		for (int b = 0; b < 2**WORDS_LOG2; b++) begin
			if (pipe[b][MEM_LAT-1].valid) begin
				rdata = pipe[b][MEM_LAT-1].data; // At most one bank valid per cycle
			end
		end
	end

endmodule

`default_nettype wire

//--- src/cache_array.sv
`timescale 1ns/1ps
`default_nettype none

module cache_array #(
	parameter type entry_t        = logic [15:0],
	parameter int  DEPTH_LOG2     = 8,
	parameter bit  CLEAR_ON_RESET = 1'b0
) (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  we,
	input  logic [DEPTH_LOG2-1:0] index,
	input  entry_t                wentry,
	output entry_t                rentry
);

	entry_t store [2**DEPTH_LOG2];

	if (CLEAR_ON_RESET) begin : g_clear
		always_ff @(posedge clk or negedge arst_n) begin
			if (!arst_n) begin
				for (int i = 0; i < 2**DEPTH_LOG2; i++) begin
					store[i] <= '0; // All lines invalid
				end
			end else if (we) begin
				store[index] <= wentry;
			end
		end
	end else begin : g_plain
		always_ff @(posedge clk) begin
			if (we) begin
				store[index] <= wentry;
			end
		end
	end

	assign rentry = store[index]; // Same-cycle read of the indexed entry

endmodule

`default_nettype wire

//--- src/cache_controller.sv
`timescale 1ns/1ps
`default_nettype none

module cache_controller import cache_pkg::*; (
	input  logic                          clk,
	input  logic                          arst_n,
	input  logic                          rd,
	input  logic                          wr,
	input  logic [15:0]                   addr,
	input  logic [15:0]                   wdata,
	input  tag_entry_t                    tag_rentry,
	input  logic [15:0]                   data_rword,
	input  logic [15:0]                   mem_rdata,
	output logic                          tag_we,
	output logic [INDEX_W-1:0]            tag_index,
	output tag_entry_t                    tag_wentry,
	output logic                          data_we,
	output logic [INDEX_W+WORDS_LOG2-1:0] data_index,
	output logic [15:0]                   data_wword,
	output mem_req_t                      mem_req,
	output logic [15:0]                   rdata,
	output logic                          done,
	output logic                          stall
);

	typedef logic [WORDS_LOG2-1:0] off_t;

	typedef struct packed {
		logic        is_wr;
		mem_addr_t   addr;
		logic [15:0] wdata;
	} cap_req_t;

	ctl_state_t state;
	ctl_state_t state_nxt;
	cap_req_t   cap;

	logic accept;
	logic hit;
	logic victim_dirty;
	off_t mem_off;  // Offset of the memory access in this state
	off_t fill_off; // Offset being refilled in this state

	assign accept       = (state == IDLE) && (rd ^ wr); // Both high is ignored
	assign hit          = tag_rentry.valid && (tag_rentry.tag == cap.addr.tag);
	assign victim_dirty = tag_rentry.valid && tag_rentry.dirty;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			cap.is_wr <= wr;
			cap.addr  <= mem_addr_t'(addr[15:1]); // Byte bit dropped
			cap.wdata <= wdata;
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (accept) begin
					state_nxt = wr ? CMP_WR : CMP_RD;
				end
			end
			CMP_RD, CMP_WR: begin
				if (hit) begin
					state_nxt = DONE;
				end else if (victim_dirty) begin
					state_nxt = WB0;
				end else begin
					state_nxt = REQ0;
				end
			end
			WB0:        state_nxt = WB1;
			WB1:        state_nxt = WB2;
			WB2:        state_nxt = WB3;
			WB3:        state_nxt = REQ0;
			REQ0:       state_nxt = REQ1;
			REQ1:       state_nxt = REQ2_FILL0;
			REQ2_FILL0: state_nxt = REQ3_FILL1;
			REQ3_FILL1: state_nxt = FILL2;
			FILL2:      state_nxt = FILL3;
			FILL3:      state_nxt = cap.is_wr ? CMP_WR : CMP_RD; // Second compare hits
			DONE:       state_nxt = IDLE;
			default:    state_nxt = IDLE;
		endcase
	end

	always_comb begin
		case (state)
			WB1, REQ1:       mem_off = off_t'(1);
			WB2, REQ2_FILL0: mem_off = off_t'(2);
			WB3, REQ3_FILL1: mem_off = off_t'(3);
			default:         mem_off = off_t'(0);
		endcase
		case (state)
			REQ3_FILL1: fill_off = off_t'(1);
			FILL2:      fill_off = off_t'(2);
			FILL3:      fill_off = off_t'(3);
			default:    fill_off = off_t'(0);
		endcase
	end

	always_comb begin
		tag_we     = 1'b0;
		tag_wentry = '{valid: 1'b1, dirty: 1'b1, tag: cap.addr.tag};
		data_we    = 1'b0;
		data_index = {cap.addr.index, cap.addr.offset};
		data_wword = cap.wdata;
		mem_req    = '{rd: 1'b0, wr: 1'b0, addr: cap.addr, wdata: data_rword};

		if (state == CMP_WR && hit) begin
			tag_we  = 1'b1; // Line becomes dirty
			data_we = 1'b1;
		end

		if (state inside {WB0, WB1, WB2, WB3}) begin
			data_index   = {cap.addr.index, mem_off};
			mem_req.wr   = 1'b1;
			mem_req.addr = '{tag: tag_rentry.tag, index: cap.addr.index, offset: mem_off};
		end

		if (state inside {REQ0, REQ1, REQ2_FILL0, REQ3_FILL1}) begin
			mem_req.rd          = 1'b1;
			mem_req.addr.offset = mem_off;
		end

		// Memory data arrives MEM_LAT cycles after each read
		if (state inside {REQ2_FILL0, REQ3_FILL1, FILL2, FILL3}) begin
			data_we    = 1'b1;
			data_index = {cap.addr.index, fill_off};
			data_wword = mem_rdata;
		end

		if (state == FILL3) begin
			tag_we           = 1'b1;
			tag_wentry.dirty = 1'b0; // Fresh line matches memory
		end
	end

	assign tag_index = cap.addr.index;
	assign rdata     = data_rword; // Indexes the requested word in DONE
	assign done      = (state == DONE);
	assign stall     = (state != IDLE) && (state != DONE);

endmodule

`default_nettype wire

//--- src/cache_pkg.sv
`default_nettype none

package cache_pkg;

	localparam int TAG_W      = 5; // Tag bits of a word address
	localparam int INDEX_W    = 8; // 256 lines
	localparam int WORDS_LOG2 = 2; // 4 words per line
	localparam int MEM_LAT    = 2; // Bank read latency in cycles

	// Word address with bit 0 of the byte address dropped
	typedef struct packed {
		logic [TAG_W-1:0]      tag;
		logic [INDEX_W-1:0]    index;
		logic [WORDS_LOG2-1:0] offset; // Also selects the memory bank
	} mem_addr_t;

	typedef struct packed {
		logic             valid;
		logic             dirty;
		logic [TAG_W-1:0] tag;
	} tag_entry_t;

	typedef struct packed {
		logic        rd;
		logic        wr;
		mem_addr_t   addr;
		logic [15:0] wdata;
	} mem_req_t;

	typedef enum logic [3:0] {
		IDLE,
		CMP_RD,
		CMP_WR,
		WB0, WB1, WB2, WB3, // Victim write-back
		REQ0, REQ1,         // First refill reads
		REQ2_FILL0,         // Read offset 2, fill offset 0
		REQ3_FILL1,         // Read offset 3, fill offset 1
		FILL2, FILL3,
		DONE
	} ctl_state_t;

endpackage

`default_nettype wire

//--- src/cache_top.sv
`timescale 1ns/1ps
`default_nettype none

module cache_top import cache_pkg::*; (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        rd,
	input  logic        wr,
	input  logic [15:0] addr,
	input  logic [15:0] wdata,
	output logic [15:0] rdata,
	output logic        done,
	output logic        stall
);

	logic                          tag_we;
	logic [INDEX_W-1:0]            tag_index;
	tag_entry_t                    tag_wentry;
	tag_entry_t                    tag_rentry;
	logic                          data_we;
	logic [INDEX_W+WORDS_LOG2-1:0] data_index;
	logic [15:0]                   data_wword;
	logic [15:0]                   data_rword;
	mem_req_t                      mem_req;
	logic [15:0]                   mem_rdata;

	cache_controller ctrl_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.rd         (rd),
		.wr         (wr),
		.addr       (addr),
		.wdata      (wdata),
		.tag_rentry (tag_rentry),
		.data_rword (data_rword),
		.mem_rdata  (mem_rdata),
		.tag_we     (tag_we),
		.tag_index  (tag_index),
		.tag_wentry (tag_wentry),
		.data_we    (data_we),
		.data_index (data_index),
		.data_wword (data_wword),
		.mem_req    (mem_req),
		.rdata      (rdata),
		.done       (done),
		.stall      (stall)
	);

	cache_array #(
		.entry_t        (tag_entry_t),
		.DEPTH_LOG2     (INDEX_W),
		.CLEAR_ON_RESET (1'b1)
	) tag_store_i (
		.clk    (clk),
		.arst_n (arst_n),
		.we     (tag_we),
		.index  (tag_index),
		.wentry (tag_wentry),
		.rentry (tag_rentry)
	);

	cache_array #(
		.entry_t        (logic [15:0]),
		.DEPTH_LOG2     (INDEX_W + WORDS_LOG2),
		.CLEAR_ON_RESET (1'b0)
	) data_store_i (
		.clk    (clk),
		.arst_n (arst_n),
		.we     (data_we),
		.index  (data_index),
		.wentry (data_wword),
		.rentry (data_rword)
	);

	bank_mem mem_i (
		.clk    (clk),
		.arst_n (arst_n),
		.req    (mem_req),
		.rdata  (mem_rdata)
	);

endmodule

`default_nettype wire

//--- tb/cache_props.sv
`timescale 1ns/1ps
`default_nettype none

module cache_props import cache_pkg::*; (
	input logic       clk,
	input logic       arst_n,
	input logic       rd,
	input logic       wr,
	input ctl_state_t state,
	input logic       done,
	input logic       stall,
	input logic       tag_we,
	input logic       data_we,
	input mem_req_t   mem_req
);

	a_done_pulse: assert property (@(posedge clk) disable iff (!arst_n) done |=> !done)
		else $error("done held for more than one cycle");

	// The busy period runs right up to done
	a_done_stall: assert property (@(posedge clk) disable iff (!arst_n) done |-> $past(stall))
		else $error("done without stall in the previous cycle");

	a_idle_stall: assert property (@(posedge clk) disable iff (!arst_n)
		(state == IDLE && !(rd ^ wr)) |=> !stall)
		else $error("stall rose in IDLE without a request");

	// Nothing may be written while waiting for a request
	a_idle_quiet: assert property (@(posedge clk) disable iff (!arst_n)
		(state == IDLE) |-> !(tag_we || data_we || mem_req.wr))
		else $error("array or memory write in IDLE");

endmodule

bind cache_controller cache_props props_i (
	.clk     (clk),
	.arst_n  (arst_n),
	.rd      (rd),
	.wr      (wr),
	.state   (state),
	.done    (done),
	.stall   (stall),
	.tag_we  (tag_we),
	.data_we (data_we),
	.mem_req (mem_req)
);

`default_nettype wire

//--- tb/tb_cache_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cache_top import cache_pkg::*; ();

	localparam int N_DIRECTED = 9;
	localparam int N_RANDOM   = 300;
	localparam int CLK_NS     = 8;
	localparam int TIMEOUT_NS = ((N_DIRECTED + N_RANDOM) * 20 + 50) * CLK_NS;

	typedef struct packed {
		logic        is_rd;
		logic [15:0] data;
		logic [7:0]  lat;   // Cycles from acceptance to done
		logic [31:0] start; // Cycle count when the request was driven
	} expect_t;

	logic        clk;
	logic        arst_n;
	logic        rd;
	logic        wr;
	logic [15:0] addr;
	logic [15:0] wdata;
	logic [15:0] rdata;
	logic        done;
	logic        stall;

	logic [15:0] ref_mem [2**15]; // Word-addressed copy of main memory
	tag_entry_t  ref_tag [2**INDEX_W];
	expect_t     exp_q [$];
	string       name_q [$];
	int          cycle;
	logic [31:0] rng;

	cache_top dut_i (
		.clk    (clk),
		.arst_n (arst_n),
		.rd     (rd),
		.wr     (wr),
		.addr   (addr),
		.wdata  (wdata),
		.rdata  (rdata),
		.done   (done),
		.stall  (stall)
	);

	initial clk = 1'b0;
	always #(CLK_NS / 2) clk = ~clk;

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Expected data and latency, and the model update for one request
	function automatic expect_t predict(input logic is_wr, input logic [15:0] a,
		input logic [15:0] d);
		tag_entry_t line;
		logic       hit;
		expect_t    e;
		line   = ref_tag[a[10:3]];
		hit    = line.valid && (line.tag == a[15:11]);
		e      = '0;
		e.lat  = hit ? 8'd2 : ((line.valid && line.dirty) ? 8'd13 : 8'd9);
		if (is_wr) begin
			ref_mem[a[15:1]] = d;
		end else begin
			e.data = ref_mem[a[15:1]];
		end
		ref_tag[a[10:3]] = '{valid: 1'b1, dirty: is_wr || (hit && line.dirty), tag: a[15:11]};
		return e;
	endfunction

	task automatic fail_stop();
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("** Error: %s expected %0h actual %0h", name, expected, actual);
			fail_stop();
		end
	endtask

	// Issues one request and with poke pulses rd again while busy
	task automatic issue_op(input string name, input logic is_wr, input logic [15:0] a,
		input logic [15:0] d, input logic poke);
		expect_t e;
		e       = predict(is_wr, a, d);
		e.is_rd = !is_wr;
		e.start = cycle;
		exp_q.push_back(e);
		name_q.push_back(name);
		rd    = !is_wr;
		wr    = is_wr;
		addr  = a;
		wdata = d;
		@(posedge clk);
		#1;
		rd    = 1'b0;
		wr    = 1'b0;
		addr  = ~a; // Must not disturb the captured request
		wdata = ~d;
		check({name, " stall"}, 32'd1, {31'd0, stall});
		if (poke) begin
			rd = 1'b1;
			@(posedge clk);
			#1;
			rd = 1'b0;
		end
		do begin
			@(negedge clk);
			if (!done) begin
				check({name, " busy stall"}, 32'd1, {31'd0, stall});
			end
		end while (!done);
		@(posedge clk);
		#1;
	endtask

	// Compare process samples on the falling edge
	always @(negedge clk) begin
		expect_t e;
		string   name;
		if (arst_n && done) begin
			if (exp_q.size() == 0) begin
				$display("The cache signalled done with no request outstanding");
				fail_stop();
			end else begin
				e    = exp_q.pop_front();
				name = name_q.pop_front();
				check({name, " latency"}, 32'(e.lat), 32'(cycle) - e.start);
				if (e.is_rd) begin
					check({name, " rdata"}, 32'(e.data), 32'(rdata));
				end
			end
		end
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Timeout after %0d ns, the cache stopped answering", TIMEOUT_NS);
		fail_stop();
	end

	initial begin
		logic [31:0] r;
		logic [15:0] a;
		cycle  = 0;
		rng    = 32'habb1;
		arst_n = 1'b0;
		rd     = 1'b0;
		wr     = 1'b0;
		addr   = '0;
		wdata  = '0;
		for (int i = 0; i < 2**15; i++) begin
			ref_mem[i] = '0;
		end
		for (int i = 0; i < 2**INDEX_W; i++) begin
			ref_tag[i] = '0;
		end
		repeat (4) @(posedge clk);
		#1;
		arst_n = 1'b1;
		@(posedge clk);
		#1;

		issue_op("cold read", 1'b0, 16'h1234, 16'h0, 1'b0);
		issue_op("cold reread", 1'b0, 16'h1234, 16'h0, 1'b0);
		issue_op("write", 1'b1, 16'h2468, 16'hbeef, 1'b0);
		issue_op("read after write", 1'b0, 16'h2468, 16'h0, 1'b0);
		issue_op("evict write A", 1'b1, 16'h0a10, 16'h5a5a, 1'b0);
		issue_op("evict write B", 1'b1, 16'h0a10 ^ 16'h0800, 16'hc3c3, 1'b0); // Same index
		issue_op("evict read A", 1'b0, 16'h0a10, 16'h0, 1'b0);
		issue_op("ignored rd", 1'b0, 16'h7ff0, 16'h0, 1'b1);
		issue_op("after ignored rd", 1'b0, 16'h7ff0, 16'h0, 1'b0);

		for (int n = 0; n < N_RANDOM; n++) begin
			rng = xorshift32(rng);
			r   = rng;
			a   = {3'b000, r[1:0], 5'b00000, r[4:2], r[7:5]}; // Tags 0..3, lines 0..7
			issue_op("random", r[8], a, r[31:16], r[11:9] == 3'd0);
		end

		repeat (20) @(posedge clk);
		if (exp_q.size() != 0) begin
			$display("%0d requests never signalled done", exp_q.size());
			fail_stop();
		end else begin
			$display("Everything OK");
			$finish;
		end
	end

endmodule

`default_nettype wire
